// ==== logic/fetch_pkg.sv ====
package fetch_pkg;

    // ************************************************
    // fetch pipeline constants
    // ************************************************
    localparam logic [31:0] reset_pc       = 32'h1c000000;
    localparam logic [31:0] fetch_step     = 32'd8;    // two instructions per group
    localparam int          ib_depth       = 8;
    localparam int          ib_ptr_w       = $clog2(ib_depth);
    localparam int          ib_cnt_w       = ib_ptr_w + 1; // count reaches ib_depth
    localparam logic [ib_cnt_w-1:0] ib_stall_level = 4;

    // exception causes carried down the fetch path
    typedef enum logic [6:0] {
        exc_adef = 7'h08,   // misaligned fetch address
        exc_pif  = 7'h03,   // reported by the cache only
        exc_tlbr = 7'h3f,   // reported by the cache only
        exc_none = 7'h7f
    } exc_cause_e;

    // one instruction buffer entry, 104 bits
    typedef struct packed {
        logic [31:0] pred_addr;
        logic [31:0] pc;
        logic [31:0] inst;
        logic        is_exception;
        exc_cause_e  cause;
    } ib_entry_t;

endpackage

// ==== logic/bpu_pkg.sv ====
package bpu_pkg;

    // ************************************************
    // BTB geometry
    // ************************************************
    localparam int btb_entries = 16;
    localparam int btb_idx_w   = 4;     // pc[5:2]
    localparam int btb_tag_w   = 26;    // pc[31:6]

    // 2-bit saturating direction counter
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,   // install and reset state
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } ctr_e;

endpackage

// ==== logic/bpu_update_if.sv ====
`timescale 1ns/1ps

// one resolved branch slot coming back from execute
interface bpu_update_if;

    logic        valid;         // slot holds a resolved instruction
    logic        is_bj;         // branch or jump
    logic [31:0] pc;
    logic        real_taken;
    logic [31:0] real_addr;     // actual target
    logic [31:0] pred_addr;     // what fetch guessed

    modport source
    (
        output valid, is_bj, pc, real_taken, real_addr, pred_addr
    );

    modport predictor
    (
        input valid, is_bj, pc, real_taken, real_addr, pred_addr
    );

endinterface

// ==== logic/fetch_pc.sv ====
`timescale 1ns/1ps

module fetch_pc
    import fetch_pkg::*;
(
    input  logic        cpu_clk,
    input  logic        reset,
    input  logic        stall,          // instruction buffer nearly full
    input  logic        pause,
    input  logic        flush,          // backend redirect
    input  logic [31:0] new_pc,
    input  logic        bpu_flush,      // misprediction redirect
    input  logic [31:0] redirect_pc,
    input  logic        pred_taken,
    input  logic [31:0] pred_addr,
    output logic [31:0] pc,
    output logic        is_exception,
    output exc_cause_e  exception_cause,
    output logic        inst_rreq
);

    logic fetch_en;     // low for the first cycle out of reset

    // ************************************************
    // next pc selection
    // ************************************************
    always_ff @(posedge cpu_clk)
    begin
        if (reset)
            pc <= reset_pc;
        else if (flush)
            pc <= new_pc;
        else if (bpu_flush)
            pc <= redirect_pc;
        else if (pause || stall)
            pc <= pc;                   // hold
        else if (pred_taken)
            pc <= pred_addr;
        else
            pc <= pc + fetch_step;
    end

    always_ff @(posedge cpu_clk)
    begin
        if (reset)
            fetch_en <= 1'b0;
        else
            fetch_en <= 1'b1;
    end

    assign inst_rreq       = fetch_en && !stall && !pause;
    assign is_exception    = |pc[1:0];                  // word aligned fetch only
    assign exception_cause = is_exception ? exc_adef : exc_none;

    a_pc_known : assert property (@(posedge cpu_clk) disable iff (reset)
        !$isunknown(pc));

endmodule

// ==== logic/branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor
    import fetch_pkg::*, bpu_pkg::*;
(
    input  logic                   cpu_clk,
    input  logic                   reset,
    input  logic [31:0]            if_pc,
    bpu_update_if.predictor        upd0,
    bpu_update_if.predictor        upd1,
    output logic                   pred_taken,
    output logic [31:0]            pred_addr,
    output logic                   bpu_flush,
    output logic [31:0]            redirect_pc
);

    logic                 btb_valid  [btb_entries];
    ctr_e                 btb_ctr    [btb_entries];
    logic [btb_tag_w-1:0] btb_tag    [btb_entries];
    logic [31:0]          btb_target [btb_entries];

    logic [31:0]          look_pc1;
    logic [btb_idx_w-1:0] l0_idx, l1_idx;
    logic                 l0_taken, l1_taken;

    logic                 u0_act, u1_act;
    logic [btb_idx_w-1:0] u0_idx, u1_idx;
    logic                 u0_hit, u1_hit;
    ctr_e                 u0_ctr, u1_ctr;
    logic [31:0]          u0_next, u1_next;
    logic                 u0_mis, u1_mis;

    function automatic ctr_e ctr_step(input ctr_e cur, input logic taken);
        ctr_e nxt;
        case (cur)
            strong_not_taken: nxt = taken ? weak_not_taken : strong_not_taken;
            weak_not_taken:   nxt = taken ? weak_taken     : strong_not_taken;
            weak_taken:       nxt = taken ? strong_taken   : weak_not_taken;
            default:          nxt = taken ? strong_taken   : weak_taken;
        endcase
        return nxt;
    endfunction

    function automatic logic [31:0] correct_next(input logic taken,
                                                 input logic [31:0] target,
                                                 input logic [31:0] pc);
        return taken ? target : pc + 32'd4;
    endfunction

    // ************************************************
    // lookup for both slots of the fetch group
    // ************************************************
    assign look_pc1 = if_pc + 32'd4;
    assign l0_idx   = if_pc[2 +: btb_idx_w];
    assign l1_idx   = look_pc1[2 +: btb_idx_w];

    assign l0_taken = btb_valid[l0_idx] && btb_tag[l0_idx] == if_pc[31 -: btb_tag_w]
                      && btb_ctr[l0_idx] inside {weak_taken, strong_taken};
    assign l1_taken = btb_valid[l1_idx] && btb_tag[l1_idx] == look_pc1[31 -: btb_tag_w]
                      && btb_ctr[l1_idx] inside {weak_taken, strong_taken};

    assign pred_taken = l0_taken || l1_taken;
    assign pred_addr  = l0_taken ? btb_target[l0_idx] :      // older slot first
                        l1_taken ? btb_target[l1_idx] : if_pc + fetch_step;

    // ************************************************
    // training from execute
    // ************************************************
    assign u0_act = upd0.valid && upd0.is_bj;
    assign u1_act = upd1.valid && upd1.is_bj;
    assign u0_idx = upd0.pc[2 +: btb_idx_w];
    assign u1_idx = upd1.pc[2 +: btb_idx_w];
    assign u0_hit = btb_valid[u0_idx] && btb_tag[u0_idx] == upd0.pc[31 -: btb_tag_w];
    assign u1_hit = btb_valid[u1_idx] && btb_tag[u1_idx] == upd1.pc[31 -: btb_tag_w];
    assign u0_ctr = ctr_step(u0_hit ? btb_ctr[u0_idx] : weak_not_taken, upd0.real_taken);
    assign u1_ctr = ctr_step(u1_hit ? btb_ctr[u1_idx] : weak_not_taken, upd1.real_taken);

    always_ff @(posedge cpu_clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < btb_entries; i++)
            begin
                btb_valid[i] <= 1'b0;
                btb_ctr[i]   <= weak_not_taken;
            end
        end
        else
        begin
            if (u0_act)
            begin
                btb_valid[u0_idx] <= 1'b1;
                btb_ctr[u0_idx]   <= u0_ctr;
            end
            if (u1_act)                     // slot 1 last so it wins a shared index
            begin
                btb_valid[u1_idx] <= 1'b1;
                btb_ctr[u1_idx]   <= u1_ctr;
            end
        end
    end

    always_ff @(posedge cpu_clk)
    begin
        if (u0_act)
        begin
            btb_tag[u0_idx] <= upd0.pc[31 -: btb_tag_w];
            if (upd0.real_taken)
                btb_target[u0_idx] <= upd0.real_addr;
        end
        if (u1_act)
        begin
            btb_tag[u1_idx] <= upd1.pc[31 -: btb_tag_w];
            if (upd1.real_taken)
                btb_target[u1_idx] <= upd1.real_addr;
        end
    end

    // misprediction check with slot 0 first
    assign u0_next = correct_next(upd0.real_taken, upd0.real_addr, upd0.pc);
    assign u1_next = correct_next(upd1.real_taken, upd1.real_addr, upd1.pc);
    assign u0_mis  = u0_act && upd0.pred_addr != u0_next;
    assign u1_mis  = u1_act && upd1.pred_addr != u1_next;

    assign bpu_flush   = u0_mis || u1_mis;
    assign redirect_pc = u0_mis ? u0_next : u1_next;

    a_redirect_known : assert property (@(posedge cpu_clk) disable iff (reset)
        bpu_flush |-> !$isunknown(redirect_pc));

endmodule

// ==== logic/inst_buffer.sv ====
`timescale 1ns/1ps

module inst_buffer
    import fetch_pkg::*;
(
    input  logic        cpu_clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        inst_valid,     // cache returns a group
    input  logic        get_data_req,   // backend takes two
    input  logic [31:0] pc1,
    input  logic [31:0] pc2,
    input  logic [31:0] inst1,
    input  logic [31:0] inst2,
    input  logic [31:0] pred_addr,
    input  logic        is_exception1,
    input  logic        is_exception2,
    input  exc_cause_e  cause1,
    input  exc_cause_e  cause2,
    output ib_entry_t   data_out1,
    output ib_entry_t   data_out2,
    output logic        data_valid,
    output logic        stall
);

    ib_entry_t            mem [ib_depth];
    logic [ib_ptr_w-1:0]  rd_ptr;
    logic [ib_ptr_w-1:0]  wr_ptr;
    logic [ib_cnt_w-1:0]  count;
    logic                 push;
    logic                 pop;
    ib_entry_t            entry1, entry2;

    assign entry1 = '{pred_addr: pred_addr, pc: pc1, inst: inst1,
                      is_exception: is_exception1, cause: cause1};
    assign entry2 = '{pred_addr: pred_addr, pc: pc2, inst: inst2,
                      is_exception: is_exception2, cause: cause2};

    assign data_valid = count >= ib_cnt_w'(2);
    assign stall      = count >= ib_stall_level;
    assign push       = inst_valid && !flush && int'(count) <= ib_depth - 2;
    assign pop        = get_data_req && data_valid;

    // ************************************************
    // pointers and fill count
    // ************************************************
    always_ff @(posedge cpu_clk)
    begin
        if (reset || flush)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + ib_ptr_w'(2);
            if (pop)
                rd_ptr <= rd_ptr + ib_ptr_w'(2);
            count <= count + (push ? ib_cnt_w'(2) : '0) - (pop ? ib_cnt_w'(2) : '0);
        end
    end

    always_ff @(posedge cpu_clk)
    begin
        if (push)
        begin
            mem[wr_ptr]                 <= entry1;
            mem[wr_ptr + ib_ptr_w'(1)]  <= entry2;
        end
    end

    // two oldest entries, read asynchronously
    assign data_out1 = mem[rd_ptr];
    assign data_out2 = mem[rd_ptr + ib_ptr_w'(1)];

    a_no_overflow : assert property (@(posedge cpu_clk) disable iff (reset || flush)
        inst_valid |-> int'(count) <= ib_depth - 2);

    a_pop_ready : assert property (@(posedge cpu_clk) disable iff (reset)
        get_data_req |-> data_valid);

endmodule

// ==== logic/fetch_front.sv ====
`timescale 1ns/1ps

module fetch_front
    import fetch_pkg::*;
(
    input  logic        cpu_clk,
    input  logic        reset,

    // backend control
    input  logic        fb_flush,
    input  logic        fb_pause,
    input  logic [31:0] fb_new_pc,
    input  logic        get_data_req,

    // ************************************************
    // instruction cache return
    // ************************************************
    input  logic        icache_pc_suspend,
    input  logic        icache_inst_valid,
    input  logic [31:0] pc_for_buffer1,
    input  logic [31:0] pc_for_buffer2,
    input  logic [31:0] inst_for_buffer1,
    input  logic [31:0] inst_for_buffer2,
    input  logic [31:0] pred_addr_for_buffer,
    input  logic        icache_is_exception1,
    input  logic        icache_is_exception2,
    input  exc_cause_e  icache_exception_cause1,
    input  exc_cause_e  icache_exception_cause2,

    // ************************************************
    // execute stage branch resolution
    // ************************************************
    input  logic        ex_valid1,
    input  logic        ex_valid2,
    input  logic        ex_is_bj1,
    input  logic        ex_is_bj2,
    input  logic [31:0] ex_pc1,
    input  logic [31:0] ex_pc2,
    input  logic        real_taken1,
    input  logic        real_taken2,
    input  logic [31:0] real_addr1,
    input  logic [31:0] real_addr2,
    input  logic [31:0] pred_addr1,
    input  logic [31:0] pred_addr2,

    // to the cache
    output logic [31:0] pi_pc,
    output logic        pi_is_exception,
    output exc_cause_e  pi_exception_cause,
    output logic        inst_rreq,
    output logic        bpu_flush,
    output logic        bpu_pred_taken,
    output logic [31:0] bpu_pred_addr,

    // to the backend
    output logic        fb_valid,
    output logic [31:0] fb_pc_out1,
    output logic [31:0] fb_pc_out2,
    output logic [31:0] fb_inst_out1,
    output logic [31:0] fb_inst_out2,
    output logic [31:0] fb_pre_branch_addr1,
    output logic [31:0] fb_pre_branch_addr2,
    output logic        fb_is_exception1,
    output logic        fb_is_exception2,
    output exc_cause_e  fb_exception_cause1,
    output exc_cause_e  fb_exception_cause2
);

    logic        ib_stall;
    logic [31:0] redirect_pc;
    ib_entry_t   data_out1, data_out2;

    bpu_update_if upd0_bus ();
    bpu_update_if upd1_bus ();

    assign upd0_bus.valid      = ex_valid1;
    assign upd0_bus.is_bj      = ex_is_bj1;
    assign upd0_bus.pc         = ex_pc1;
    assign upd0_bus.real_taken = real_taken1;
    assign upd0_bus.real_addr  = real_addr1;
    assign upd0_bus.pred_addr  = pred_addr1;

    assign upd1_bus.valid      = ex_valid2;
    assign upd1_bus.is_bj      = ex_is_bj2;
    assign upd1_bus.pc         = ex_pc2;
    assign upd1_bus.real_taken = real_taken2;
    assign upd1_bus.real_addr  = real_addr2;
    assign upd1_bus.pred_addr  = pred_addr2;

    fetch_pc fetch_pc_i
    (
        .cpu_clk         (cpu_clk),
        .reset           (reset),
        .stall           (ib_stall),
        .pause           (fb_pause || icache_pc_suspend),
        .flush           (fb_flush),
        .new_pc          (fb_new_pc),
        .bpu_flush       (bpu_flush),
        .redirect_pc     (redirect_pc),
        .pred_taken      (bpu_pred_taken),
        .pred_addr       (bpu_pred_addr),
        .pc              (pi_pc),
        .is_exception    (pi_is_exception),
        .exception_cause (pi_exception_cause),
        .inst_rreq       (inst_rreq)
    );

    branch_predictor branch_predictor_i
    (
        .cpu_clk     (cpu_clk),
        .reset       (reset),
        .if_pc       (pi_pc),
        .upd0        (upd0_bus),
        .upd1        (upd1_bus),
        .pred_taken  (bpu_pred_taken),
        .pred_addr   (bpu_pred_addr),
        .bpu_flush   (bpu_flush),
        .redirect_pc (redirect_pc)
    );

    inst_buffer inst_buffer_i
    (
        .cpu_clk       (cpu_clk),
        .reset         (reset),
        .flush         (fb_flush || bpu_flush),     // either redirect drops queued groups
        .inst_valid    (icache_inst_valid),
        .get_data_req  (get_data_req),
        .pc1           (pc_for_buffer1),
        .pc2           (pc_for_buffer2),
        .inst1         (inst_for_buffer1),
        .inst2         (inst_for_buffer2),
        .pred_addr     (pred_addr_for_buffer),
        .is_exception1 (icache_is_exception1),
        .is_exception2 (icache_is_exception2),
        .cause1        (icache_exception_cause1),
        .cause2        (icache_exception_cause2),
        .data_out1     (data_out1),
        .data_out2     (data_out2),
        .data_valid    (fb_valid),
        .stall         (ib_stall)
    );

    // unpack buffer entries for the backend
    assign fb_pre_branch_addr1 = data_out1.pred_addr;
    assign fb_pre_branch_addr2 = data_out2.pred_addr;
    assign fb_pc_out1          = data_out1.pc;
    assign fb_pc_out2          = data_out2.pc;
    assign fb_inst_out1        = data_out1.inst;
    assign fb_inst_out2        = data_out2.inst;
    assign fb_is_exception1    = data_out1.is_exception;
    assign fb_is_exception2    = data_out2.is_exception;
    assign fb_exception_cause1 = data_out1.cause;
    assign fb_exception_cause2 = data_out2.cause;

endmodule

// ==== dv/fetch_front_tb.sv ====
`timescale 1ns/1ps

module fetch_front_tb
    import fetch_pkg::*;
();

    typedef struct packed {
        logic        valid;
        logic        is_bj;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] real_addr;
        logic [31:0] pred_addr;
    } upd_t;

    typedef struct packed {
        logic [4:0]  ctl;
        logic [31:0] new_pc;
        upd_t        u0;
        upd_t        u1;
        logic        exp_taken;     // prediction expected at the current pc
        logic [31:0] exp_target;
    } step_t;

    localparam logic [4:0]  c_idle  = 5'b00000;
    localparam logic [4:0]  c_flush = 5'b00001;
    localparam logic [4:0]  c_pause = 5'b00010;
    localparam logic [4:0]  c_susp  = 5'b00100;
    localparam logic [4:0]  c_iv    = 5'b01000;
    localparam logic [4:0]  c_get   = 5'b10000;
    localparam upd_t        no_upd  = '0;
    localparam logic [31:0] x_br    = 32'h1c000400;    // trained branch at btb index 0
    localparam logic [31:0] t_br    = 32'h1c000800;

    logic        cpu_clk;
    logic        reset;
    logic        fb_flush, fb_pause, get_data_req;
    logic [31:0] fb_new_pc;
    logic        icache_pc_suspend, icache_inst_valid;
    logic [31:0] pc_for_buffer1, pc_for_buffer2, inst_for_buffer1, inst_for_buffer2;
    logic [31:0] pred_addr_for_buffer;
    logic        icache_is_exception1, icache_is_exception2;
    exc_cause_e  icache_exception_cause1, icache_exception_cause2;
    logic        ex_valid1, ex_valid2, ex_is_bj1, ex_is_bj2;
    logic [31:0] ex_pc1, ex_pc2;
    logic        real_taken1, real_taken2;
    logic [31:0] real_addr1, real_addr2, pred_addr1, pred_addr2;
    logic [31:0] pi_pc;
    logic        pi_is_exception;
    exc_cause_e  pi_exception_cause;
    logic        inst_rreq, bpu_flush, bpu_pred_taken;
    logic [31:0] bpu_pred_addr;
    logic        fb_valid;
    logic [31:0] fb_pc_out1, fb_pc_out2, fb_inst_out1, fb_inst_out2;
    logic [31:0] fb_pre_branch_addr1, fb_pre_branch_addr2;
    logic        fb_is_exception1, fb_is_exception2;
    exc_cause_e  fb_exception_cause1, fb_exception_cause2;

    step_t       steps[$];
    ib_entry_t   model_q[$];        // mirrors the instruction buffer
    logic [31:0] exp_pc;
    logic [31:0] rng_state = 32'h2817;
    int          errors = 0;
    int          checks = 0;

    fetch_front fetch_front_i (.*);

    initial
    begin
        cpu_clk = 1'b0;
        forever
            #4 cpu_clk = ~cpu_clk;
    end

    // ************************************************
    // helpers
    // ************************************************
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic upd_t resolved(input logic [31:0] pc, input logic taken,
                                      input logic [31:0] real_addr,
                                      input logic [31:0] pred_addr);
        upd_t u;
        u.valid     = 1'b1;
        u.is_bj     = 1'b1;
        u.pc        = pc;
        u.taken     = taken;
        u.real_addr = real_addr;
        u.pred_addr = pred_addr;
        return u;
    endfunction

    // slot with valid or is_bj low, never trains and never flushes
    function automatic upd_t ignored(input logic valid, input logic is_bj,
                                     input logic [31:0] pc, input logic [31:0] pred_addr);
        upd_t u;
        u       = resolved(pc, 1'b0, 32'h0, pred_addr);
        u.valid = valid;
        u.is_bj = is_bj;
        return u;
    endfunction

    // where execute says the program really goes next
    function automatic logic [31:0] correct_target(input upd_t u);
        return u.taken ? u.real_addr : u.pc + 32'd4;
    endfunction

    function automatic logic mispredicts(input upd_t u);
        return u.valid && u.is_bj && u.pred_addr != correct_target(u);
    endfunction

    task automatic add_step(input logic [4:0] ctl, input logic [31:0] new_pc,
                            input upd_t u0, input upd_t u1,
                            input logic exp_taken, input logic [31:0] exp_target);
        step_t s;
        s = '{ctl, new_pc, u0, u1, exp_taken, exp_target};
        steps.push_back(s);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        checks++;
        assert (got === want)
        else
        begin
            errors++;
            $display("ERR t=%0t %s expected %h got %h", $time, name, want, got);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        checks++;
        assert (got === want)
        else
        begin
            errors++;
            $display("ERR t=%0t %s expected %b got %b", $time, name, want, got);
        end
    endtask

    task automatic check_entry(input string sfx, input ib_entry_t got, input ib_entry_t want);
        check_word({"fb_pc_out", sfx}, got.pc, want.pc);
        check_word({"fb_inst_out", sfx}, got.inst, want.inst);
        check_word({"fb_pre_branch_addr", sfx}, got.pred_addr, want.pred_addr);
        check_bit({"fb_is_exception", sfx}, got.is_exception, want.is_exception);
        check_word({"fb_exception_cause", sfx}, 32'(got.cause), 32'(want.cause));
    endtask

    task automatic init_inputs();
        reset                   = 1'b1;
        fb_flush                = 1'b0;
        fb_pause                = 1'b0;
        fb_new_pc               = 32'h0;
        get_data_req            = 1'b0;
        icache_pc_suspend       = 1'b0;
        icache_inst_valid       = 1'b0;
        pc_for_buffer1          = 32'h0;
        pc_for_buffer2          = 32'h0;
        inst_for_buffer1        = 32'h0;
        inst_for_buffer2        = 32'h0;
        pred_addr_for_buffer    = 32'h0;
        icache_is_exception1    = 1'b0;
        icache_is_exception2    = 1'b0;
        icache_exception_cause1 = exc_none;
        icache_exception_cause2 = exc_none;
        {ex_valid1, ex_is_bj1, ex_pc1, real_taken1, real_addr1, pred_addr1} = '0;
        {ex_valid2, ex_is_bj2, ex_pc2, real_taken2, real_addr2, pred_addr2} = '0;
    endtask

    task automatic drive_step(input step_t s);
        logic [31:0] r;
        fb_flush          = |(s.ctl & c_flush);
        fb_pause          = |(s.ctl & c_pause);
        icache_pc_suspend = |(s.ctl & c_susp);
        icache_inst_valid = |(s.ctl & c_iv);
        get_data_req      = |(s.ctl & c_get);
        fb_new_pc         = s.new_pc;
        if (icache_inst_valid)
        begin
            r                       = next_random();
            pc_for_buffer1          = exp_pc;
            pc_for_buffer2          = exp_pc + 32'd4;
            pred_addr_for_buffer    = exp_pc + 32'd8;
            inst_for_buffer1        = next_random();
            inst_for_buffer2        = next_random();
            icache_is_exception1    = r[0];
            icache_exception_cause1 = r[0] ? exc_tlbr : exc_none;
            icache_is_exception2    = r[1];
            icache_exception_cause2 = r[1] ? exc_pif : exc_none;
        end
        ex_valid1   = s.u0.valid;
        ex_is_bj1   = s.u0.is_bj;
        ex_valid2   = s.u1.valid;
        ex_is_bj2   = s.u1.is_bj;
        ex_pc1      = s.u0.pc;
        real_taken1 = s.u0.taken;
        real_addr1  = s.u0.real_addr;
        pred_addr1  = s.u0.pred_addr;
        ex_pc2      = s.u1.pc;
        real_taken2 = s.u1.taken;
        real_addr2  = s.u1.real_addr;
        pred_addr2  = s.u1.pred_addr;
    endtask

    // ************************************************
    // checks and reference model
    // ************************************************
    task automatic check_step(input step_t s, input int idx);
        logic      stall_exp;
        logic      misaligned;
        ib_entry_t got1, got2;
        stall_exp  = model_q.size() >= int'(ib_stall_level);
        misaligned = |exp_pc[1:0];
        check_word("pi_pc", pi_pc, exp_pc);
        check_bit("pi_is_exception", pi_is_exception, misaligned);
        check_word("pi_exception_cause", 32'(pi_exception_cause),
                   misaligned ? 32'(exc_adef) : 32'(exc_none));
        check_bit("inst_rreq", inst_rreq,
                  idx > 0 && !stall_exp && !fb_pause && !icache_pc_suspend);
        check_bit("bpu_flush", bpu_flush, mispredicts(s.u0) || mispredicts(s.u1));
        check_bit("bpu_pred_taken", bpu_pred_taken, s.exp_taken);
        if (s.exp_taken)
            check_word("bpu_pred_addr", bpu_pred_addr, s.exp_target);
        check_bit("fb_valid", fb_valid, model_q.size() >= 2);
        if (model_q.size() >= 2)
        begin
            got1 = '{pred_addr: fb_pre_branch_addr1, pc: fb_pc_out1, inst: fb_inst_out1,
                     is_exception: fb_is_exception1, cause: fb_exception_cause1};
            got2 = '{pred_addr: fb_pre_branch_addr2, pc: fb_pc_out2, inst: fb_inst_out2,
                     is_exception: fb_is_exception2, cause: fb_exception_cause2};
            check_entry("1", got1, model_q[0]);
            check_entry("2", got2, model_q[1]);
        end
    endtask

    task automatic advance_model(input step_t s);
        logic      mis;
        logic      hold;
        logic      push_ok;
        ib_entry_t e1, e2;
        mis  = mispredicts(s.u0) || mispredicts(s.u1);
        hold = fb_pause || icache_pc_suspend || model_q.size() >= int'(ib_stall_level);
        if (fb_flush)
            exp_pc = s.new_pc;
        else if (mis)
            exp_pc = mispredicts(s.u0) ? correct_target(s.u0) : correct_target(s.u1);
        else if (!hold)
            exp_pc = s.exp_taken ? s.exp_target : exp_pc + 32'd8;

        e1 = '{pred_addr: pred_addr_for_buffer, pc: pc_for_buffer1, inst: inst_for_buffer1,
               is_exception: icache_is_exception1, cause: icache_exception_cause1};
        e2 = '{pred_addr: pred_addr_for_buffer, pc: pc_for_buffer2, inst: inst_for_buffer2,
               is_exception: icache_is_exception2, cause: icache_exception_cause2};
        if (fb_flush || mis)
            model_q.delete();               // any redirect drops queued groups
        else
        begin
            push_ok = icache_inst_valid && model_q.size() <= ib_depth - 2;
            if (get_data_req && model_q.size() >= 2)
            begin
                void'(model_q.pop_front());
                void'(model_q.pop_front());
            end
            if (push_ok)
            begin
                model_q.push_back(e1);
                model_q.push_back(e2);
            end
        end
    endtask

    // ************************************************
    // stimulus table
    // ************************************************
    task automatic build_table();
        add_step(c_idle, 32'h0, no_upd, no_upd, 1'b0, 32'h0);      // first cycle out of reset
        add_step(c_idle, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_pause, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_susp, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_idle, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_flush, 32'h1c000102, no_upd, no_upd, 1'b0, 32'h0); // misaligned target
        add_step(c_flush, 32'h1c000200, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_idle, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        // fill without reads until the stall holds the pc
        add_step(c_iv, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_iv, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_iv, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_idle, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_get, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_get | c_iv, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_get, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_get, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_iv, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_iv, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_flush, 32'h1c000300, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_idle, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_iv, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        // ************************************************
        // btb training then misprediction
        // ************************************************
        add_step(c_idle, 32'h0, resolved(x_br, 1'b1, t_br, t_br), no_upd, 1'b0, 32'h0);
        add_step(c_flush, x_br, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_idle, 32'h0, no_upd, no_upd, 1'b1, t_br);      // slot 0 hit
        add_step(c_idle, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_flush, x_br - 32'd4, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_idle, 32'h0, no_upd, no_upd, 1'b1, t_br);      // slot 1 hit
        add_step(c_idle, 32'h0, resolved(x_br, 1'b0, t_br, x_br + 32'd4), no_upd, 1'b0, 32'h0);
        add_step(c_flush, x_br, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_iv, 32'h0, no_upd, no_upd, 1'b0, 32'h0);       // counter back below taken
        add_step(c_idle, 32'h0, resolved(32'h1c000500, 1'b0, 32'h0, 32'h1c000600), no_upd,
                 1'b0, 32'h0);
        add_step(c_idle, 32'h0, resolved(32'h1c000520, 1'b1, 32'h1c000a00, 32'h1c000524),
                 resolved(32'h1c000524, 1'b0, 32'h0, 32'h1c000a40), 1'b0, 32'h0);
        add_step(c_flush, 32'h1c000c00, resolved(32'h1c000530, 1'b0, 32'h0, 32'h0), no_upd,
                 1'b0, 32'h0);
        // a slot acts only with valid and is_bj both high
        add_step(c_idle, 32'h0, ignored(1'b1, 1'b0, 32'h1c000540, 32'h0),
                 ignored(1'b0, 1'b1, 32'h1c000544, 32'h0), 1'b0, 32'h0);
        // slot 1 alone mispredicts
        add_step(c_idle, 32'h0, resolved(32'h1c000560, 1'b0, 32'h0, 32'h1c000564),
                 resolved(32'h1c000564, 1'b1, 32'h1c000e00, 32'h1c000568), 1'b0, 32'h0);
        add_step(c_iv, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_get, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
        add_step(c_idle, 32'h0, no_upd, no_upd, 1'b0, 32'h0);
    endtask

    initial
    begin
        step_t s;
        init_inputs();
        exp_pc = reset_pc;
        build_table();
        repeat (3) @(posedge cpu_clk);
        for (int i = 0; i < steps.size(); i++)
        begin
            @(negedge cpu_clk);
            reset = 1'b0;
            s = steps[i];
            drive_step(s);
            #2;                             // outputs settled, well before the rising edge
            check_step(s, i);
            advance_model(s);
        end
        @(negedge cpu_clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog sized from the table length
    initial
    begin
        #1;
        #(steps.size() * 8 + 200);
        $display("watchdog timeout, the stimulus table did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== src.f ====
logic/fetch_pkg.sv
logic/bpu_pkg.sv
logic/bpu_update_if.sv
logic/fetch_pc.sv
logic/branch_predictor.sv
logic/inst_buffer.sv
logic/fetch_front.sv
dv/fetch_front_tb.sv

// ==== Makefile ====
TOP = fetch_front_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Simulation completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log
